/* files.f */
+incdir+include
logic/wrr_pkg.sv
logic/wrr_ifs.sv
logic/wrr_decode.sv
logic/wrr_flow_table.sv
logic/wrr_result.sv
logic/wrr_rank_top.sv
bench/tb_clock_gen.sv
bench/tb_wrr_rank.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f files.f \
   --top-module tb_wrr_rank --Mdir obj_dir -o tb_wrr_rank

./obj_dir/tb_wrr_rank > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* bench/tb_wrr_rank.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

module tb_wrr_rank
   import wrr_pkg::*;
();

   localparam int IDLE_CYC = 20;
   localparam int RD_CNT   = 16;
   localparam int PKT_CYC  = 600;
   localparam int OVF_PKTS = 2049;
   localparam int BAD_CNT  = 8;
   localparam int TIMEOUT_CYC = 3 + IDLE_CYC + 2 * RD_CNT + `WRR_FLOW_CNT + PKT_CYC
                                + OVF_PKTS + 2 + 3 * BAD_CNT + 8 + 50;
   localparam logic [7:0] OVF_FLOW = 8'd127;   // Port 3, class 31

   logic clk_cp, rst;
   logic pkt_valid_i, cpu_valid_i, cpu_write_i, cpu_read_i;
   logic [`WRR_PORT_W-1:0] pkt_port_i;
   logic [`WRR_CLASS_W-1:0] pkt_class_i;
   flow_id_t cpu_index_i, cpu_index_o;
   logic [`WRR_WEIGHT_W-1:0] cpu_weight_i;
   logic rank_valid_o, cpu_valid_o;
   rank_t rank_o;
   cpu_val_t cpu_val_o;

   integer seed = 32'ha5f19ed6;
   int cycle = 0;
   int val_errors = 0;
   int hs_errors = 0;
   int i;
   int due;
   logic [31:0] r;
   flow_id_t bad [BAD_CNT];
   rank_t exp_rank;
   cpu_val_t exp_val;
   flow_id_t exp_idx;

   // Reference copy of the flow table
   flow_state_t model_state [`WRR_FLOW_CNT];
   logic [7:0] model_cfg [`WRR_FLOW_CNT];

   rank_t rank_q [$];
   int rank_due_q [$];
   cpu_val_t cpu_q [$];
   flow_id_t cpu_idx_q [$];
   int cpu_due_q [$];

   tb_clock_gen u_clk (.clk_o(clk_cp), .rst_o(rst));

   wrr_rank_top UUT (
      .clk_cp       (clk_cp),
      .rst          (rst),
      .pkt_valid_i  (pkt_valid_i),
      .pkt_port_i   (pkt_port_i),
      .pkt_class_i  (pkt_class_i),
      .cpu_valid_i  (cpu_valid_i),
      .cpu_write_i  (cpu_write_i),
      .cpu_read_i   (cpu_read_i),
      .cpu_index_i  (cpu_index_i),
      .cpu_weight_i (cpu_weight_i),
      .rank_valid_o (rank_valid_o),
      .rank_o       (rank_o),
      .cpu_valid_o  (cpu_valid_o),
      .cpu_index_o  (cpu_index_o),
      .cpu_val_o    (cpu_val_o)
   );

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic [2:0] port_to_id(input logic [7:0] port);
      case (port)
         8'h01:   return 3'd0;
         8'h04:   return 3'd1;
         8'h10:   return 3'd2;
         8'h40:   return 3'd3;
         default: return 3'd4;      // CPU port
      endcase
   endfunction

   function automatic flow_state_t wrr_next(input flow_state_t cur, input logic [7:0] cfg);
      flow_state_t nxt;
      nxt = cur;
      if (cur.weight >= cfg)
      begin
         nxt.weight = 8'd1;         // Round used up
         if (cur.round == 11'd2047)
         begin
            nxt.round = 11'd1;
            nxt.ovf   = cur.ovf + 2'd1;
         end
         else
            nxt.round = cur.round + 11'd1;
      end
      else
         nxt.weight = cur.weight + 8'd1;
      return nxt;
   endfunction

   function automatic cpu_val_t cpu_expect(input logic wr, input logic [7:0] idx,
                                           input logic [7:0] wt);
      cpu_val_t v;
      v = '0;
      if (idx < `WRR_FLOW_CNT)
      begin
         v.round  = model_state[idx].round;
         v.weight = model_state[idx].weight;
         v.cfg    = wr ? wt : model_cfg[idx];
         v.ovf    = wr ? 2'd0 : model_state[idx].ovf;
      end
      return v;
   endfunction

   // Valid flows only, classes 0..15 so flow 127 stays untouched
   function automatic logic [7:0] rand_index();
      logic [31:0] x;
      x = $random(seed);
      return {3'(x[15:0] % 5), 1'b0, x[19:16]};
   endfunction

   function automatic logic [7:0] rand_port();
      logic [31:0] x;
      x = $random(seed);
      return x[2] ? (8'h01 << (2 * x[1:0])) : x[15:8];
   endfunction

   function automatic logic [4:0] rand_class();
      logic [31:0] x;
      x = $random(seed);
      return x[3] ? {3'd0, x[1:0]} : {1'b0, x[7:4]};   // Small set forces repeats
   endfunction

   ////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
         val_errors++;
      end
   endtask

   // One cycle of inputs; CPU sees state before the packet, packet sees old config
   task automatic drive_cycle(input logic pv, input logic [7:0] port, input logic [4:0] cls,
                              input logic cv, input logic wr, input logic [7:0] idx,
                              input logic [7:0] wt);
      flow_id_t fid;
      @(negedge clk_cp);
      pkt_valid_i  = pv;
      pkt_port_i   = port;
      pkt_class_i  = cls;
      cpu_valid_i  = cv;
      cpu_write_i  = cv && wr;
      cpu_read_i   = cv && !wr;
      cpu_index_i  = idx;
      cpu_weight_i = wt;
      if (cv)
      begin
         cpu_q.push_back(cpu_expect(wr, idx, wt));
         cpu_idx_q.push_back(idx);
         cpu_due_q.push_back(cycle + 3);
      end
      if (pv)
      begin
         fid = {port_to_id(port), cls};
         model_state[fid] = wrr_next(model_state[fid], model_cfg[fid]);
         rank_q.push_back({model_state[fid].ovf, model_state[fid].round, cls});
         rank_due_q.push_back(cycle + 3);
      end
      if (cv && wr && idx < `WRR_FLOW_CNT)
         model_cfg[idx] = wt;
   endtask

   always @(posedge clk_cp)
   begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYC)
      begin
         $display("Timeout after %0d cycles with outputs still outstanding", cycle);
         $display("Test failed");
         $finish;
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk_cp)
   begin
      if (rst)
      begin
         if (rank_q.size() != 0 && rank_due_q[0] == cycle)
         begin
            exp_rank = rank_q.pop_front();
            due = rank_due_q.pop_front();
            if (!rank_valid_o)
            begin
               $display("Missing rank_valid_o at %0t for a packet due in cycle %0d",
                        $time, due);
               hs_errors++;
            end
            else
               check_value("rank_o", exp_rank, rank_o);
         end
         else if (rank_valid_o)
         begin
            $display("Unexpected rank_valid_o at %0t with no packet due", $time);
            hs_errors++;
         end

         if (cpu_q.size() != 0 && cpu_due_q[0] == cycle)
         begin
            exp_val = cpu_q.pop_front();
            exp_idx = cpu_idx_q.pop_front();
            due = cpu_due_q.pop_front();
            if (!cpu_valid_o)
            begin
               $display("Missing cpu_valid_o at %0t for a CPU access due in cycle %0d",
                        $time, due);
               hs_errors++;
            end
            else
            begin
               check_value("cpu_index_o", exp_idx, cpu_index_o);
               check_value("cpu_val_o", exp_val, cpu_val_o);
            end
         end
         else if (cpu_valid_o)
         begin
            $display("Unexpected cpu_valid_o at %0t with no CPU access due", $time);
            hs_errors++;
         end
      end
   end

   initial
   begin
      pkt_valid_i = 1'b0;
      pkt_port_i = '0;
      pkt_class_i = '0;
      cpu_valid_i = 1'b0;
      cpu_write_i = 1'b0;
      cpu_read_i = 1'b0;
      cpu_index_i = '0;
      cpu_weight_i = '0;
      for (i = 0; i < `WRR_FLOW_CNT; i++)
      begin
         model_state[i] = '0;
         model_cfg[i] = '0;
      end
      wait (rst === 1'b1);

      // Quiet outputs, then reads of a cleared table
      repeat (IDLE_CYC) drive_cycle(0, 8'h00, 5'd0, 0, 0, 8'd0, 8'd0);
      for (i = 0; i < RD_CNT; i++)
         drive_cycle(0, 8'h00, 5'd0, 1, 0, rand_index(), 8'd0);

      // Config weights for every flow
      for (i = 0; i < `WRR_FLOW_CNT; i++)
      begin
         r = $random(seed);
         drive_cycle(0, 8'h00, 5'd0, 1, 1, 8'(i), {5'd0, r[2:0]});
      end
      for (i = 0; i < RD_CNT; i++)
         drive_cycle(0, 8'h00, 5'd0, 1, 0, rand_index(), 8'd0);

      // Random packet traffic mixed with CPU accesses
      for (i = 0; i < PKT_CYC; i++)
      begin
         r = $random(seed);
         drive_cycle(r[0] | r[1], rand_port(), rand_class(), r[30:29] == 2'd0, r[31],
                     rand_index(), {5'd0, r[12:10]});
      end

      // Round wrap on a zero-weight flow
      drive_cycle(0, 8'h00, 5'd0, 1, 1, OVF_FLOW, 8'd0);
      repeat (OVF_PKTS) drive_cycle(1, 8'h40, 5'd31, 0, 0, 8'd0, 8'd0);
      drive_cycle(0, 8'h00, 5'd0, 1, 0, OVF_FLOW, 8'd0);

      // Out-of-range indices, then their low aliases
      for (i = 0; i < BAD_CNT; i++)
      begin
         bad[i] = 8'(160 + {$random(seed)} % 96);
         drive_cycle(0, 8'h00, 5'd0, 1, 1, bad[i], 8'hff);
      end
      for (i = 0; i < BAD_CNT; i++)
         drive_cycle(0, 8'h00, 5'd0, 1, 0, bad[i], 8'd0);
      for (i = 0; i < BAD_CNT; i++)
         drive_cycle(0, 8'h00, 5'd0, 1, 0, bad[i] - 8'd160, 8'd0);

      while (rank_q.size() != 0 || cpu_q.size() != 0)
         drive_cycle(0, 8'h00, 5'd0, 0, 0, 8'd0, 8'd0);
      repeat (5) drive_cycle(0, 8'h00, 5'd0, 0, 0, 8'd0, 8'd0);

      $display("Errors: %0d value, %0d handshake", val_errors, hs_errors);
      if (val_errors == 0 && hs_errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk_o,
   output logic rst_o
);

   // 10 ns period
   initial
   begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial
   begin
      rst_o = 1'b0;                 // Active low
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b1;
   end

endmodule

/* logic/wrr_rank_top.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

module wrr_rank_top
   import wrr_pkg::*;
(
   input  logic                     clk_cp,
   input  logic                     rst,
   // Packet side
   input  logic                     pkt_valid_i,
   input  logic [`WRR_PORT_W-1:0]   pkt_port_i,
   input  logic [`WRR_CLASS_W-1:0]  pkt_class_i,
   // CPU side
   input  logic                     cpu_valid_i,
   input  logic                     cpu_write_i,
   input  logic                     cpu_read_i,
   input  flow_id_t                 cpu_index_i,
   input  logic [`WRR_WEIGHT_W-1:0] cpu_weight_i,
   // Results, three cycles after the request
   output logic                     rank_valid_o,
   output rank_t                    rank_o,
   output logic                     cpu_valid_o,
   output flow_id_t                 cpu_index_o,
   output cpu_val_t                 cpu_val_o
);

   wrr_req_if req_bus ();
   wrr_res_if res_bus ();

   wrr_decode u_decode (
      .clk_cp       (clk_cp),
      .rst          (rst),
      .pkt_valid_i  (pkt_valid_i),
      .pkt_port_i   (pkt_port_i),
      .pkt_class_i  (pkt_class_i),
      .cpu_valid_i  (cpu_valid_i),
      .cpu_write_i  (cpu_write_i),
      .cpu_read_i   (cpu_read_i),
      .cpu_index_i  (cpu_index_i),
      .cpu_weight_i (cpu_weight_i),
      .req          (req_bus.dec)
   );

   wrr_flow_table u_flow_table (
      .clk_cp (clk_cp),
      .rst    (rst),
      .req    (req_bus.exe),
      .res    (res_bus.exe)
   );

   wrr_result u_result (
      .clk_cp       (clk_cp),
      .rst          (rst),
      .res          (res_bus.res),
      .rank_valid_o (rank_valid_o),
      .rank_o       (rank_o),
      .cpu_valid_o  (cpu_valid_o),
      .cpu_index_o  (cpu_index_o),
      .cpu_val_o    (cpu_val_o)
   );

endmodule

/* logic/wrr_result.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

module wrr_result
   import wrr_pkg::*;
(
   input  logic   clk_cp,
   input  logic   rst,
   wrr_res_if.res res,
   output logic   rank_valid_o,
   output rank_t  rank_o,
   output logic   cpu_valid_o,
   output flow_id_t cpu_index_o,
   output cpu_val_t cpu_val_o
);

   rank_t    rank_nxt;
   cpu_val_t val_nxt;

   always_comb
   begin
      rank_nxt.ovf   = res.state.ovf;
      rank_nxt.round = res.state.round;
      rank_nxt.cls   = res.rank_class;
   end

   // Write echoes the new weight with overflow held at zero
   always_comb
   begin
      val_nxt = '0;
      if (res.rsp_ok)
      begin
         val_nxt.round  = res.rsp_state.round;
         val_nxt.cfg    = res.rsp_cfg;
         val_nxt.weight = res.rsp_state.weight;
         if (!res.rsp_write)
         begin
            val_nxt.ovf = res.rsp_state.ovf;
         end
      end
   end

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         rank_valid_o <= 1'b0;
         rank_o       <= '0;
         cpu_valid_o  <= 1'b0;
         cpu_index_o  <= '0;
         cpu_val_o    <= '0;
      end
      else
      begin
         rank_valid_o <= res.rank_valid;
         rank_o       <= res.rank_valid ? rank_nxt : '0;
         cpu_valid_o  <= res.rsp_valid;
         cpu_index_o  <= res.rsp_valid ? res.rsp_index : '0;
         cpu_val_o    <= res.rsp_valid ? val_nxt : '0;
      end
   end

endmodule

/* logic/wrr_flow_table.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

module wrr_flow_table
   import wrr_pkg::*;
(
   input  logic   clk_cp,
   input  logic   rst,
   wrr_req_if.exe req,
   wrr_res_if.exe res
);

   flow_state_t              state_q [`WRR_FLOW_CNT];
   logic [`WRR_WEIGHT_W-1:0] cfg_q   [`WRR_FLOW_CNT];

   flow_state_t              pkt_cur;
   flow_state_t              pkt_nxt;
   logic [`WRR_WEIGHT_W-1:0] pkt_cfg;
   flow_id_t                 cpu_sel;

   assign pkt_cur = state_q[req.flow_id];
   assign pkt_cfg = cfg_q[req.flow_id];    // Old value even when a write lands now

   // Bad indices read entry 0, the output stage blanks them anyway
   assign cpu_sel = req.index_ok ? req.cpu_index : '0;

   ////////////////////////////////////////
   // WRR step for one packet
   ////////////////////////////////////////

   always_comb
   begin
      pkt_nxt = pkt_cur;
      if (pkt_cur.weight < pkt_cfg)
      begin
         pkt_nxt.weight = pkt_cur.weight + 1'b1;   // Still inside this round
      end
      else
      begin
         pkt_nxt.weight = `WRR_WEIGHT_W'(1);
         if (pkt_cur.round < `WRR_ROUND_MAX)
         begin
            pkt_nxt.round = pkt_cur.round + 1'b1;
         end
         else
         begin
            // Round space used up, restart at 1 one overflow later
            pkt_nxt.round = `WRR_ROUND_W'(1);
            pkt_nxt.ovf   = pkt_cur.ovf + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Table storage
   ////////////////////////////////////////

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         for (int i = 0; i < `WRR_FLOW_CNT; i++)
         begin
            state_q[i] <= '0;
            cfg_q[i]   <= '0;
         end
      end
      else
      begin
         if (req.pkt_valid)
         begin
            state_q[req.flow_id] <= pkt_nxt;
         end
         if (req.cpu_write && req.index_ok)
         begin
            cfg_q[req.cpu_index] <= req.cpu_weight;
         end
      end
   end

   ////////////////////////////////////////
   // Stage registers toward the output
   ////////////////////////////////////////

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         res.rank_valid <= 1'b0;
         res.rsp_valid  <= 1'b0;
      end
      else
      begin
         res.rank_valid <= req.pkt_valid;
         res.rsp_valid  <= req.cpu_write || req.cpu_read;
      end
   end

   always_ff @(posedge clk_cp)
   begin
      res.state      <= pkt_nxt;
      res.rank_class <= req.pkt_class;
      res.rsp_write  <= req.cpu_write;
      res.rsp_index  <= req.cpu_index;
      res.rsp_state  <= state_q[cpu_sel];          // Before this cycle's packet
      res.rsp_cfg    <= req.cpu_write ? req.cpu_weight : cfg_q[cpu_sel];
      res.rsp_ok     <= req.index_ok;
   end

   // Decode only builds ids from ports 0..4
   a_flow_in_range: assert property (@(posedge clk_cp) disable iff (!rst)
      req.pkt_valid |-> req.flow_id < `WRR_INDEX_W'(`WRR_FLOW_CNT));

endmodule

/* logic/wrr_decode.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

module wrr_decode
   import wrr_pkg::*;
(
   input  logic                     clk_cp,
   input  logic                     rst,
   input  logic                     pkt_valid_i,
   input  logic [`WRR_PORT_W-1:0]   pkt_port_i,
   input  logic [`WRR_CLASS_W-1:0]  pkt_class_i,
   input  logic                     cpu_valid_i,
   input  logic                     cpu_write_i,
   input  logic                     cpu_read_i,
   input  flow_id_t                 cpu_index_i,
   input  logic [`WRR_WEIGHT_W-1:0] cpu_weight_i,
   wrr_req_if.dec                   req
);

   localparam int PORT_ID_W = `WRR_INDEX_W - `WRR_CLASS_W;

   logic [PORT_ID_W-1:0] port_id;

   // One-hot port byte to port id, stray patterns go to the CPU port
   always_comb
   begin
      case (pkt_port_i)
         8'h01:   port_id = PORT_ID_W'(0);
         8'h04:   port_id = PORT_ID_W'(1);
         8'h10:   port_id = PORT_ID_W'(2);
         8'h40:   port_id = PORT_ID_W'(3);
         default: port_id = PORT_ID_W'(`WRR_PORT_CNT - 1);
      endcase
   end

   ////////////////////////////////////////
   // Request registers
   ////////////////////////////////////////

   always_ff @(posedge clk_cp)
   begin
      if (!rst)
      begin
         req.pkt_valid <= 1'b0;
         req.cpu_write <= 1'b0;
         req.cpu_read  <= 1'b0;
      end
      else
      begin
         req.pkt_valid <= pkt_valid_i;
         req.cpu_write <= cpu_valid_i && cpu_write_i;
         req.cpu_read  <= cpu_valid_i && cpu_read_i && !cpu_write_i;   // Write wins
      end
   end

   always_ff @(posedge clk_cp)
   begin
      req.flow_id    <= {port_id, pkt_class_i};
      req.pkt_class  <= pkt_class_i;
      req.cpu_index  <= cpu_index_i;
      req.cpu_weight <= cpu_weight_i;
      req.index_ok   <= cpu_index_i < `WRR_INDEX_W'(`WRR_FLOW_CNT);
   end

   // CPU side must pick one access type per request
   a_cpu_one_op: assert property (@(posedge clk_cp) disable iff (!rst)
      cpu_valid_i |-> !(cpu_write_i && cpu_read_i));

endmodule

/* logic/wrr_ifs.sv */
`timescale 1ns/1ps
`include "wrr_macros.svh"

// Decoded requests, decode stage to execute stage
interface wrr_req_if import wrr_pkg::*; ();
   logic                     pkt_valid;
   flow_id_t                 flow_id;
   logic [`WRR_CLASS_W-1:0]  pkt_class;
   logic                     cpu_write;
   logic                     cpu_read;
   flow_id_t                 cpu_index;
   logic [`WRR_WEIGHT_W-1:0] cpu_weight;
   logic                     index_ok;    // Index inside the flow table

   modport dec (output pkt_valid, flow_id, pkt_class,
                output cpu_write, cpu_read, cpu_index, cpu_weight, index_ok);
   modport exe (input pkt_valid, flow_id, pkt_class,
                input cpu_write, cpu_read, cpu_index, cpu_weight, index_ok);
endinterface

// Execute results, execute stage to output stage
interface wrr_res_if import wrr_pkg::*; ();
   logic                     rank_valid;
   flow_state_t              state;       // Flow state after the packet
   logic [`WRR_CLASS_W-1:0]  rank_class;
   logic                     rsp_valid;
   logic                     rsp_write;
   flow_id_t                 rsp_index;
   flow_state_t              rsp_state;   // Snapshot before any packet update
   logic [`WRR_WEIGHT_W-1:0] rsp_cfg;
   logic                     rsp_ok;

   modport exe (output rank_valid, state, rank_class,
                output rsp_valid, rsp_write, rsp_index, rsp_state, rsp_cfg, rsp_ok);
   modport res (input rank_valid, state, rank_class,
                input rsp_valid, rsp_write, rsp_index, rsp_state, rsp_cfg, rsp_ok);
endinterface

/* logic/wrr_pkg.sv */
`include "wrr_macros.svh"

package wrr_pkg;

   // Port id in the upper bits, class in the lower bits
   typedef logic [`WRR_INDEX_W-1:0] flow_id_t;

   // Rank handed to the PIFO, compared as one number
   typedef struct packed {
      logic [`WRR_OVF_W-1:0]   ovf;
      logic [`WRR_ROUND_W-1:0] round;
      logic [`WRR_CLASS_W-1:0] cls;
   } rank_t;

   // Per-flow scheduling state
   typedef struct packed {
      logic [`WRR_OVF_W-1:0]    ovf;
      logic [`WRR_ROUND_W-1:0]  round;
      logic [`WRR_WEIGHT_W-1:0] weight;
   } flow_state_t;

   // Value returned on the CPU channel
   typedef struct packed {
      logic [`WRR_OVF_W-1:0]    ovf;
      logic [`WRR_ROUND_W-1:0]  round;
      logic [`WRR_WEIGHT_W-1:0] cfg;      // Configured weight
      logic [`WRR_WEIGHT_W-1:0] weight;   // Packets sent in the current round
   } cpu_val_t;

endpackage

/* include/wrr_macros.svh */
`ifndef WRR_MACROS_SVH
`define WRR_MACROS_SVH

////////////////////////////////////////
// Flow table dimensions
////////////////////////////////////////

`define WRR_PORT_CNT   5     // nf0..nf3 plus the CPU port
`define WRR_CLASS_W    5
`define WRR_CLASS_CNT  32    // Classes per port
`define WRR_FLOW_CNT   (`WRR_PORT_CNT * `WRR_CLASS_CNT)

////////////////////////////////////////
// Field widths
////////////////////////////////////////

`define WRR_PORT_W     8     // One-hot port byte from the pipeline
`define WRR_INDEX_W    8     // 3-bit port id, then the class
`define WRR_WEIGHT_W   8
`define WRR_ROUND_W    11
`define WRR_OVF_W      2

// Last round before the overflow count steps
`define WRR_ROUND_MAX  11'd2047

`endif
